//--- rtl/iq_dsp_pkg.sv
`default_nettype none

package iq_dsp_pkg;

  // datapath widths
  localparam int SIGNAL_BITS = 14;           // adc sample
  localparam int LUT_SZ      = 11;           // log2 of table depth
  localparam int LUT_BITS    = 17;           // sine word
  localparam int PHASE_BITS  = 32;           // accumulator
  localparam int QUAD_BITS   = 24;           // demodulated quadrature
  localparam int SUM_BITS    = 62;           // averager sums

  // sine table geometry
  localparam int LUT_DEPTH   = 1 << LUT_SZ;
  localparam int LUT_QUARTER = 1 << (LUT_SZ - 2);  // 90 deg in table steps
  localparam int SIN_AMP     = 65535;              // full scale, fits signed 17b
  localparam real TWO_PI     = 6.283185307179586;

  // product of sample and sine word, then scaled down to quadrature width
  localparam int PROD_BITS   = SIGNAL_BITS + LUT_BITS;
  localparam int DEMOD_SHIFT = SIGNAL_BITS + LUT_BITS - QUAD_BITS;  // = 7

  typedef logic signed [SIGNAL_BITS-1:0] sample_t;
  typedef logic        [PHASE_BITS-1:0]  phase_t;
  typedef logic signed [LUT_BITS-1:0]    lut_t;
  typedef logic signed [QUAD_BITS-1:0]   quad_t;
  typedef logic signed [SUM_BITS-1:0]    sum_t;

  // in-phase / quadrature travel together
  typedef struct packed {
    quad_t i;
    quad_t q;
  } iq_pair_t;

endpackage

`default_nettype wire

//--- rtl/iq_cfg_pkg.sv
`default_nettype none

package iq_cfg_pkg;

  typedef logic [15:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [31:0] cfg_word_t;  // one config register

  // register map, byte addresses
  localparam bus_addr_t ADDR_PHASE_INC   = 16'h0104;  // nco frequency word
  localparam bus_addr_t ADDR_PHASE_SHIFT = 16'h0108;  // phase offset, write also triggers NA
  localparam bus_addr_t ADDR_NA_AVG      = 16'h0130;  // cycles to sum
  localparam bus_addr_t ADDR_NA_SLEEP    = 16'h0134;  // settling cycles before sum
  localparam bus_addr_t ADDR_SUM_I_LO    = 16'h0140;
  localparam bus_addr_t ADDR_SUM_I_HI    = 16'h0144;
  localparam bus_addr_t ADDR_SUM_Q_LO    = 16'h0148;
  localparam bus_addr_t ADDR_SUM_Q_HI    = 16'h014C;

  // read-only width words
  localparam bus_addr_t ADDR_W_LUTSZ     = 16'h0200;
  localparam bus_addr_t ADDR_W_LUTBITS   = 16'h0204;
  localparam bus_addr_t ADDR_W_PHASE     = 16'h0208;
  localparam bus_addr_t ADDR_W_SIGNAL    = 16'h020C;
  localparam bus_addr_t ADDR_W_QUAD      = 16'h0210;

  // all writable registers in one bundle
  typedef struct packed {
    cfg_word_t phase_inc;
    cfg_word_t phase_shift;
    cfg_word_t na_averages;
    cfg_word_t na_sleep;
  } iq_cfg_t;

  // network analyser sequencer
  typedef enum logic [1:0] {
    NA_IDLE,
    NA_SLEEP,
    NA_SUM
  } na_state_t;

endpackage

`default_nettype wire

//--- rtl/iq_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module iq_reg_decode (
  input  wire                   clk_i,
  input  wire                   rstn_i,
  input  iq_cfg_pkg::bus_addr_t addr_i,
  input  wire                   wen_i,
  input  wire                   ren_i,
  input  iq_cfg_pkg::bus_data_t wdata_i,
  input  iq_dsp_pkg::sum_t      sum_i,
  input  iq_dsp_pkg::sum_t      sum_q,
  input  wire                   busy_i,
  output logic                  ack_o,
  output iq_cfg_pkg::bus_data_t rdata_o,
  output iq_cfg_pkg::iq_cfg_t   cfg_o,
  output logic                  na_start_o
);

  iq_cfg_pkg::bus_data_t rd_mux;  // readback before the output flop

  // config registers, write strobe and trigger
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      cfg_o      <= '0;
      ack_o      <= 1'b0;
      na_start_o <= 1'b0;
    end else begin
      ack_o      <= wen_i | ren_i;  // every access acked next cycle
      na_start_o <= wen_i && (addr_i == iq_cfg_pkg::ADDR_PHASE_SHIFT);
      if (wen_i) begin
        case (addr_i)
          iq_cfg_pkg::ADDR_PHASE_INC:   cfg_o.phase_inc   <= wdata_i;
          iq_cfg_pkg::ADDR_PHASE_SHIFT: cfg_o.phase_shift <= wdata_i;
          iq_cfg_pkg::ADDR_NA_AVG:      cfg_o.na_averages <= wdata_i;
          iq_cfg_pkg::ADDR_NA_SLEEP:    cfg_o.na_sleep    <= wdata_i;
          default: ;  // read-only or unmapped
        endcase
      end
    end
  end

  // readback select
  // sum words carry busy in bit 31, 31 sum bits below
  always_comb begin
    case (addr_i)
      iq_cfg_pkg::ADDR_PHASE_INC:   rd_mux = cfg_o.phase_inc;
      iq_cfg_pkg::ADDR_PHASE_SHIFT: rd_mux = cfg_o.phase_shift;
      iq_cfg_pkg::ADDR_NA_AVG:      rd_mux = cfg_o.na_averages;
      iq_cfg_pkg::ADDR_NA_SLEEP:    rd_mux = cfg_o.na_sleep;
      iq_cfg_pkg::ADDR_SUM_I_LO:    rd_mux = {busy_i, sum_i[30:0]};
      iq_cfg_pkg::ADDR_SUM_I_HI:    rd_mux = {busy_i, sum_i[61:31]};
      iq_cfg_pkg::ADDR_SUM_Q_LO:    rd_mux = {busy_i, sum_q[30:0]};
      iq_cfg_pkg::ADDR_SUM_Q_HI:    rd_mux = {busy_i, sum_q[61:31]};
      iq_cfg_pkg::ADDR_W_LUTSZ:
        rd_mux = iq_cfg_pkg::bus_data_t'(iq_dsp_pkg::LUT_SZ);
      iq_cfg_pkg::ADDR_W_LUTBITS:
        rd_mux = iq_cfg_pkg::bus_data_t'(iq_dsp_pkg::LUT_BITS);
      iq_cfg_pkg::ADDR_W_PHASE:
        rd_mux = iq_cfg_pkg::bus_data_t'(iq_dsp_pkg::PHASE_BITS);
      iq_cfg_pkg::ADDR_W_SIGNAL:
        rd_mux = iq_cfg_pkg::bus_data_t'(iq_dsp_pkg::SIGNAL_BITS);
      iq_cfg_pkg::ADDR_W_QUAD:
        rd_mux = iq_cfg_pkg::bus_data_t'(iq_dsp_pkg::QUAD_BITS);
      default:                      rd_mux = '0;  // unmapped reads zero
    endcase
  end

  // data word sampled with the access, valid alongside ack
  always_ff @(posedge clk_i) begin
    rdata_o <= rd_mux;
  end

  // one strobe per access, acked on the next edge
  a_ack_follows_strobe : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
      (wen_i || ren_i) |-> !(wen_i && ren_i) ##1 ack_o
  );

endmodule

`default_nettype wire

//--- rtl/iq_nco.sv
`timescale 1ns/1ps
`default_nettype none

module iq_nco (
  input  wire                 clk_i,
  input  wire                 rstn_i,
  input  wire                 sync_i,   // high runs the accumulator
  input  iq_cfg_pkg::iq_cfg_t cfg_i,
  output iq_dsp_pkg::lut_t    cos_o,
  output iq_dsp_pkg::lut_t    sin_o
);

  iq_dsp_pkg::phase_t phase_acc;  // free-running phase
  iq_dsp_pkg::phase_t phase_r;    // acc + offset, stage 1

  logic [iq_dsp_pkg::LUT_SZ-1:0] sin_addr;
  logic [iq_dsp_pkg::LUT_SZ-1:0] cos_addr;

  // full-wave sine rom
  iq_dsp_pkg::lut_t sin_lut [0:iq_dsp_pkg::LUT_DEPTH-1];

  initial begin
    real ang;
    for (int k = 0; k < iq_dsp_pkg::LUT_DEPTH; k++) begin
      ang = iq_dsp_pkg::TWO_PI * k / iq_dsp_pkg::LUT_DEPTH;
      // round to nearest, symmetric about zero crossing
      sin_lut[k] = iq_dsp_pkg::lut_t'($rtoi($floor(iq_dsp_pkg::SIN_AMP * $sin(ang) + 0.5)));
    end
  end

  // accumulator, held at zero while sync low
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      phase_acc <= '0;
    end else if (!sync_i) begin
      phase_acc <= '0;  // re-align all channels
    end else begin
      phase_acc <= phase_acc + cfg_i.phase_inc;
    end
  end

  // stage 1: apply the phase offset
  always_ff @(posedge clk_i) begin
    phase_r <= phase_acc + cfg_i.phase_shift;
  end

  assign sin_addr = phase_r[iq_dsp_pkg::PHASE_BITS-1 -: iq_dsp_pkg::LUT_SZ];
  // cos leads sin by a quarter turn, wraps naturally
  assign cos_addr = sin_addr + iq_dsp_pkg::LUT_SZ'(iq_dsp_pkg::LUT_QUARTER);

  // stage 2: table lookup
  always_ff @(posedge clk_i) begin
    sin_o <= sin_lut[sin_addr];
    cos_o <= sin_lut[cos_addr];
  end

endmodule

`default_nettype wire

//--- rtl/iq_demodulator.sv
`timescale 1ns/1ps
`default_nettype none

module iq_demodulator (
  input  wire                   clk_i,
  input  iq_dsp_pkg::sample_t   dat_i,
  input  iq_dsp_pkg::lut_t      cos_i,
  input  iq_dsp_pkg::lut_t      sin_i,
  output iq_dsp_pkg::iq_pair_t  iq_o
);

  // input stage
  iq_dsp_pkg::sample_t dat_r;
  iq_dsp_pkg::lut_t    cos_r;
  iq_dsp_pkg::lut_t    sin_r;

  // full-width signed products
  logic signed [iq_dsp_pkg::PROD_BITS-1:0] prod_i;
  logic signed [iq_dsp_pkg::PROD_BITS-1:0] prod_q;

  // stage 1: register operands, keeps the multiplier off the rom path
  always_ff @(posedge clk_i) begin
    dat_r <= dat_i;
    cos_r <= cos_i;
    sin_r <= sin_i;
  end

  // 14b x 17b signed, no overflow at full scale
  assign prod_i = dat_r * cos_r;  // in-phase
  assign prod_q = dat_r * sin_r;  // quadrature

  // stage 2: drop the low bits, keep sign
  always_ff @(posedge clk_i) begin
    iq_o.i <= iq_dsp_pkg::quad_t'(prod_i >>> iq_dsp_pkg::DEMOD_SHIFT);
    iq_o.q <= iq_dsp_pkg::quad_t'(prod_q >>> iq_dsp_pkg::DEMOD_SHIFT);
  end

endmodule

`default_nettype wire

//--- rtl/iq_na_averager.sv
`timescale 1ns/1ps
`default_nettype none

module iq_na_averager (
  input  wire                   clk_i,
  input  wire                   rstn_i,
  input  wire                   na_start_i,  // one-cycle trigger
  input  iq_cfg_pkg::iq_cfg_t   cfg_i,
  input  iq_dsp_pkg::iq_pair_t  iq_i,
  output iq_dsp_pkg::sum_t      sum_i_o,
  output iq_dsp_pkg::sum_t      sum_q_o,
  output logic                  busy_o
);

  iq_cfg_pkg::na_state_t state;
  iq_cfg_pkg::cfg_word_t sleep_cnt;  // settling cycles left
  iq_cfg_pkg::cfg_word_t avg_cnt;    // samples left to add

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state     <= iq_cfg_pkg::NA_IDLE;
      sleep_cnt <= '0;
      avg_cnt   <= '0;
      sum_i_o   <= '0;
      sum_q_o   <= '0;
    end else if (na_start_i) begin
      // restart from any state
      sum_i_o   <= '0;
      sum_q_o   <= '0;
      sleep_cnt <= cfg_i.na_sleep;
      avg_cnt   <= cfg_i.na_averages;
      if (cfg_i.na_averages == '0)
        state <= iq_cfg_pkg::NA_IDLE;   // nothing to sum
      else if (cfg_i.na_sleep == '0)
        state <= iq_cfg_pkg::NA_SUM;    // no settling wanted
      else
        state <= iq_cfg_pkg::NA_SLEEP;
    end else begin
      case (state)
        iq_cfg_pkg::NA_SLEEP: begin
          sleep_cnt <= sleep_cnt - 32'd1;
          if (sleep_cnt == 32'd1) state <= iq_cfg_pkg::NA_SUM;
        end
        iq_cfg_pkg::NA_SUM: begin
          // sign-extend quadratures into the wide sums
          sum_i_o <= sum_i_o + iq_dsp_pkg::sum_t'(iq_i.i);
          sum_q_o <= sum_q_o + iq_dsp_pkg::sum_t'(iq_i.q);
          avg_cnt <= avg_cnt - 32'd1;
          if (avg_cnt == 32'd1) state <= iq_cfg_pkg::NA_IDLE;  // last sample
        end
        default: state <= iq_cfg_pkg::NA_IDLE;
      endcase
    end
  end

  assign busy_o = (state != iq_cfg_pkg::NA_IDLE);  // sleeping or summing

  // results are frozen between runs so software can read both halves
  a_sums_hold_in_idle : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
      (state == iq_cfg_pkg::NA_IDLE && !na_start_i)
        |=> ($stable(sum_i_o) && $stable(sum_q_o))
  );

endmodule

`default_nettype wire

//--- rtl/iq_block_top.sv
`timescale 1ns/1ps
`default_nettype none

module iq_block_top (
  input  wire                   clk_i,
  input  wire                   rstn_i,
  input  wire                   sync_i,     // nco run, low re-aligns phase
  input  iq_dsp_pkg::sample_t   dat_i,
  output iq_dsp_pkg::sample_t   signal_o,   // in-phase, top bits
  output iq_dsp_pkg::sample_t   signal2_o,  // quadrature, top bits
  // register bus
  input  iq_cfg_pkg::bus_addr_t addr_i,
  input  wire                   wen_i,
  input  wire                   ren_i,
  input  iq_cfg_pkg::bus_data_t wdata_i,
  output logic                  ack_o,
  output iq_cfg_pkg::bus_data_t rdata_o
);

  iq_cfg_pkg::iq_cfg_t  cfg;
  logic                 na_start;
  iq_dsp_pkg::lut_t     cos;
  iq_dsp_pkg::lut_t     sin;
  iq_dsp_pkg::iq_pair_t iq;
  iq_dsp_pkg::sum_t     sum_i;
  iq_dsp_pkg::sum_t     sum_q;
  logic                 busy;

  iq_reg_decode u_decode (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .addr_i     (addr_i),
    .wen_i      (wen_i),
    .ren_i      (ren_i),
    .wdata_i    (wdata_i),
    .sum_i      (sum_i),
    .sum_q      (sum_q),
    .busy_i     (busy),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o),
    .cfg_o      (cfg),
    .na_start_o (na_start)
  );

  iq_nco u_nco (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .sync_i (sync_i),
    .cfg_i  (cfg),
    .cos_o  (cos),
    .sin_o  (sin)
  );

  iq_demodulator u_demod (
    .clk_i (clk_i),
    .dat_i (dat_i),
    .cos_i (cos),
    .sin_i (sin),
    .iq_o  (iq)
  );

  iq_na_averager u_na (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .na_start_i (na_start),
    .cfg_i      (cfg),
    .iq_i       (iq),
    .sum_i_o    (sum_i),
    .sum_q_o    (sum_q),
    .busy_o     (busy)
  );

  // msbs of the quadratures straight out, unfiltered
  assign signal_o  = iq.i[iq_dsp_pkg::QUAD_BITS-1 -: iq_dsp_pkg::SIGNAL_BITS];
  assign signal2_o = iq.q[iq_dsp_pkg::QUAD_BITS-1 -: iq_dsp_pkg::SIGNAL_BITS];

endmodule

`default_nettype wire

//--- test/iq_block_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iq_block_tb;

  localparam int NUM_ROWS = 6;
  localparam int CLK_HALF = 10;  // 20 ns period

  // one case of the table, predicted quadratures alongside
  typedef struct packed {
    iq_dsp_pkg::sample_t dat;
    logic [31:0]         shift;
    logic [31:0]         avg;
    logic [31:0]         sleep;
    iq_dsp_pkg::quad_t   exp_i;
    iq_dsp_pkg::quad_t   exp_q;
  } stim_row_t;

  logic                  clk_i;
  logic                  rstn_i;
  logic                  sync_i;
  iq_dsp_pkg::sample_t   dat_i;
  iq_dsp_pkg::sample_t   signal_o;
  iq_dsp_pkg::sample_t   signal2_o;
  iq_cfg_pkg::bus_addr_t addr_i;
  logic                  wen_i;
  logic                  ren_i;
  iq_cfg_pkg::bus_data_t wdata_i;
  logic                  ack_o;
  iq_cfg_pkg::bus_data_t rdata_o;

  stim_row_t table_rows [NUM_ROWS];
  int        checks;
  int        errors;
  int        cycle_cnt = 0;
  int        cycle_limit;  // set from the table at time 0

  iq_block_top UUT (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .sync_i    (sync_i),
    .dat_i     (dat_i),
    .signal_o  (signal_o),
    .signal2_o (signal2_o),
    .addr_i    (addr_i),
    .wen_i     (wen_i),
    .ren_i     (ren_i),
    .wdata_i   (wdata_i),
    .ack_o     (ack_o),
    .rdata_o   (rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // watchdog on cycle count
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run stopped after %0d clock cycles", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, msg, got, exp);
    end
  endtask

  // table value of cos at a whole quarter turn
  function automatic int cos_amp(input int quadrant);
    case (quadrant % 4)
      0:       return iq_dsp_pkg::SIN_AMP;
      2:       return -iq_dsp_pkg::SIN_AMP;
      default: return 0;  // zero crossings
    endcase
  endfunction

  function automatic int sin_amp(input int quadrant);
    return cos_amp(quadrant + 3);  // sine lags a quarter turn
  endfunction

  // sample times table word, arithmetic shift down to quadrature width
  function automatic iq_dsp_pkg::quad_t predict_quad(input iq_dsp_pkg::sample_t dat,
                                                     input int amp);
    longint prod;
    prod = longint'(dat) * longint'(amp);
    return iq_dsp_pkg::quad_t'(prod >>> iq_dsp_pkg::DEMOD_SHIFT);
  endfunction

  // |sample| >= 4096 so the top output bits move
  function automatic iq_dsp_pkg::sample_t random_sample();
    iq_dsp_pkg::sample_t s;
    s = iq_dsp_pkg::sample_t'($urandom);
    s[12] = ~s[13];
    return s;
  endfunction

  task automatic build_table();
    int avg_list [NUM_ROWS];
    int sleep_list [NUM_ROWS];
    int budget;
    avg_list   = '{5, 16, 1, 33, 100, 7};
    sleep_list = '{8, 10, 12, 9, 20, 8};  // >= 8 lets the pipeline settle
    budget     = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      table_rows[r].dat   = random_sample();
      // quarter-turn offset, low bits below the table address are noise
      table_rows[r].shift = (32'(r % 4) << 30) | ($urandom & 32'h000F_FFFF);
      table_rows[r].avg   = 32'(avg_list[r]);
      table_rows[r].sleep = 32'(sleep_list[r]);
      table_rows[r].exp_i = predict_quad(table_rows[r].dat, cos_amp(r));
      table_rows[r].exp_q = predict_quad(table_rows[r].dat, sin_amp(r));
      budget += sleep_list[r] + avg_list[r] + 40;
    end
    cycle_limit = 2 * budget;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic bus_write(input iq_cfg_pkg::bus_addr_t addr,
                           input iq_cfg_pkg::bus_data_t data);
    @(negedge clk_i);
    compare_values(64'(ack_o), 64'd0, "ack low before write");
    addr_i  = addr;
    wdata_i = data;
    wen_i   = 1'b1;
    @(negedge clk_i);
    wen_i = 1'b0;
    compare_values(64'(ack_o), 64'd1, $sformatf("ack after write to 0x%h", addr));
  endtask

  task automatic bus_read(input iq_cfg_pkg::bus_addr_t addr,
                          output iq_cfg_pkg::bus_data_t data);
    @(negedge clk_i);
    compare_values(64'(ack_o), 64'd0, "ack low before read");
    addr_i = addr;
    ren_i  = 1'b1;
    @(negedge clk_i);
    ren_i = 1'b0;
    compare_values(64'(ack_o), 64'd1, $sformatf("ack after read of 0x%h", addr));
    data = rdata_o;  // registered word, stable at the falling edge
  endtask

  task automatic check_read(input iq_cfg_pkg::bus_addr_t addr,
                            input iq_cfg_pkg::bus_data_t exp, input string msg);
    iq_cfg_pkg::bus_data_t rd;
    bus_read(addr, rd);
    compare_values(64'(rd), 64'(exp), msg);
  endtask

  // two words, 31 sum bits each
  task automatic read_sum(input iq_cfg_pkg::bus_addr_t lo_addr,
                          input iq_cfg_pkg::bus_addr_t hi_addr,
                          output iq_dsp_pkg::sum_t sum);
    iq_cfg_pkg::bus_data_t lo;
    iq_cfg_pkg::bus_data_t hi;
    bus_read(lo_addr, lo);
    bus_read(hi_addr, hi);
    sum = {hi[30:0], lo[30:0]};
  endtask

  task automatic check_outputs(input iq_dsp_pkg::quad_t exp_i, input iq_dsp_pkg::quad_t exp_q,
                               input string tag);
    compare_values({50'd0, signal_o}, {50'd0, exp_i[23:10]}, {tag, " signal_o"});
    compare_values({50'd0, signal2_o}, {50'd0, exp_q[23:10]}, {tag, " signal2_o"});
  endtask

  initial begin
    iq_cfg_pkg::bus_addr_t zero_addrs [10];
    iq_cfg_pkg::bus_addr_t rw_addrs [3];
    iq_cfg_pkg::bus_data_t rd;
    iq_cfg_pkg::bus_data_t val;
    iq_dsp_pkg::sum_t      sum_i;
    iq_dsp_pkg::sum_t      sum_q;
    iq_dsp_pkg::sample_t   last_i;
    iq_dsp_pkg::sample_t   last_q;
    int                    changes;
    void'($urandom(9));
    rstn_i    = 1'b0;
    sync_i    = 1'b0;  // nco held, phase = offset only
    dat_i     = '0;
    addr_i    = '0;
    wen_i     = 1'b0;
    ren_i     = 1'b0;
    wdata_i   = '0;
    checks    = 0;
    errors    = 0;
    build_table();
    repeat (3) @(negedge clk_i);
    rstn_i = 1'b1;

    // reset state, unmapped space, width words
    zero_addrs = '{iq_cfg_pkg::ADDR_PHASE_INC, iq_cfg_pkg::ADDR_PHASE_SHIFT,
                   iq_cfg_pkg::ADDR_NA_AVG, iq_cfg_pkg::ADDR_NA_SLEEP,
                   iq_cfg_pkg::ADDR_SUM_I_LO, iq_cfg_pkg::ADDR_SUM_I_HI,
                   iq_cfg_pkg::ADDR_SUM_Q_LO, iq_cfg_pkg::ADDR_SUM_Q_HI,
                   16'h0100, 16'h0300};
    foreach (zero_addrs[k])
      check_read(zero_addrs[k], '0, $sformatf("reset read of 0x%h", zero_addrs[k]));
    check_read(iq_cfg_pkg::ADDR_W_LUTSZ, 32'(iq_dsp_pkg::LUT_SZ), "lut size word");
    check_read(iq_cfg_pkg::ADDR_W_LUTBITS, 32'(iq_dsp_pkg::LUT_BITS), "lut bits word");
    check_read(iq_cfg_pkg::ADDR_W_PHASE, 32'(iq_dsp_pkg::PHASE_BITS), "phase bits word");
    check_read(iq_cfg_pkg::ADDR_W_SIGNAL, 32'(iq_dsp_pkg::SIGNAL_BITS), "signal bits word");
    check_read(iq_cfg_pkg::ADDR_W_QUAD, 32'(iq_dsp_pkg::QUAD_BITS), "quad bits word");

    // plain read/write registers, none of these triggers the averager
    rw_addrs = '{iq_cfg_pkg::ADDR_PHASE_INC, iq_cfg_pkg::ADDR_NA_AVG,
                 iq_cfg_pkg::ADDR_NA_SLEEP};
    foreach (rw_addrs[k]) begin
      val = $urandom;
      bus_write(rw_addrs[k], val);
      check_read(rw_addrs[k], val, $sformatf("readback of 0x%h", rw_addrs[k]));
    end

    // table loop: static outputs, then averaged sums
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(negedge clk_i);
      dat_i = table_rows[r].dat;
      bus_write(iq_cfg_pkg::ADDR_NA_AVG, table_rows[r].avg);
      bus_write(iq_cfg_pkg::ADDR_NA_SLEEP, table_rows[r].sleep);
      bus_write(iq_cfg_pkg::ADDR_PHASE_SHIFT, table_rows[r].shift);  // starts a run
      wait_cycles(6);  // nco 2 + demodulator 2, margin
      check_outputs(table_rows[r].exp_i, table_rows[r].exp_q, $sformatf("row %0d", r));
      rd = 32'h8000_0000;
      while (rd[31])
        bus_read(iq_cfg_pkg::ADDR_SUM_I_LO, rd);  // busy in bit 31
      read_sum(iq_cfg_pkg::ADDR_SUM_I_LO, iq_cfg_pkg::ADDR_SUM_I_HI, sum_i);
      read_sum(iq_cfg_pkg::ADDR_SUM_Q_LO, iq_cfg_pkg::ADDR_SUM_Q_HI, sum_q);
      compare_values(64'(sum_i), 64'(62'(longint'(table_rows[r].avg) *
                     longint'(table_rows[r].exp_i))), $sformatf("row %0d sum i", r));
      compare_values(64'(sum_q), 64'(62'(longint'(table_rows[r].avg) *
                     longint'(table_rows[r].exp_q))), $sformatf("row %0d sum q", r));
    end

    // zero averages: sums cleared, never busy
    bus_write(iq_cfg_pkg::ADDR_NA_AVG, 32'd0);
    bus_write(iq_cfg_pkg::ADDR_PHASE_SHIFT, 32'h4000_0000);
    check_read(iq_cfg_pkg::ADDR_SUM_I_LO, '0, "zero-average sum i lo");
    check_read(iq_cfg_pkg::ADDR_SUM_I_HI, '0, "zero-average sum i hi");
    check_read(iq_cfg_pkg::ADDR_SUM_Q_LO, '0, "zero-average sum q lo");
    check_read(iq_cfg_pkg::ADDR_SUM_Q_HI, '0, "zero-average sum q hi");

    // running nco, outputs rotate
    bus_write(iq_cfg_pkg::ADDR_PHASE_INC, 32'h0123_4567);
    @(negedge clk_i);
    sync_i = 1'b1;
    wait_cycles(6);
    changes = 0;
    last_i  = signal_o;
    last_q  = signal2_o;
    repeat (20) begin
      @(negedge clk_i);
      if (signal_o !== last_i || signal2_o !== last_q) changes++;
      last_i = signal_o;
      last_q = signal2_o;
    end
    compare_values(64'(changes > 5), 64'd1, "outputs move while sync high");
    @(negedge clk_i);
    sync_i = 1'b0;  // accumulator back to zero
    wait_cycles(6);
    check_outputs(predict_quad(dat_i, cos_amp(1)), predict_quad(dat_i, sin_amp(1)),
                  "after sync drop");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
rtl/iq_dsp_pkg.sv
rtl/iq_cfg_pkg.sv
rtl/iq_reg_decode.sv
rtl/iq_nco.sv
rtl/iq_demodulator.sv
rtl/iq_na_averager.sv
rtl/iq_block_top.sv
test/iq_block_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the iq block testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module iq_block_tb -Mdir "$OBJ" -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Viq_block_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0
